// File: uart_tx_pkg.sv
// UART transmitter package with frame constants, FSM states and controller strobes
package uart_tx_pkg;

    // **************************************************
    // Frame format
    // **************************************************

    // Number of data bits in a frame
    localparam int DATA_BITS = 8;

    // Line levels of the start and stop bits
    // The idle line sits at the stop level
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

    // **************************************************
    // Controller
    // **************************************************

    typedef enum logic [2:0] {
        IDLE,
        SEND_START,
        CLEAR_TIMER,
        SEND_DATA,
        TEST_EOC,
        SHIFT_COUNT,
        SEND_STOP
    } t_states;

    // Flags from the datapath
    typedef struct packed {
        logic t1;
        logic eoc_dcount;
    } t_uart_tx_ctrl_in;

    // Strobes to the datapath
    typedef struct packed {
        logic ena_load;
        logic clr_dcount;
        logic te;
        logic clr_tx;
        logic ena_tx;
        logic set_tx;
        logic ena_shift;
        logic ena_dcount;
    } t_uart_tx_ctrl_out;

endpackage

// File: uart_axil_pkg.sv
// AXI4-Lite package with channel structs, register map, response codes and write views
package uart_axil_pkg;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // Register offsets
    localparam logic [AXIL_ADDR_W-1:0] ADDR_DIV    = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_DATA   = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 4'h8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Master to slave
    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } t_axil_req;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } t_axil_rsp;

    // Write word seen through the divisor register
    typedef struct packed {
        logic [15:0] rsvd;
        logic [15:0] divisor;
    } t_div_view;

    // Write word seen through the data register
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  data_byte;
    } t_data_view;

    // The write address picks which view applies
    typedef union packed {
        t_div_view  div;
        t_data_view data;
    } t_wr_word;

endpackage

// File: uart_tx_ctrl.sv
// UART transmit controller, Moore FSM that sequences the start, data and stop bits
`timescale 1ns/1ps

module uart_tx_ctrl (
    input  logic                                clk,
    input  logic                                resetN,
    input  logic                                write_din,
    input  var uart_tx_pkg::t_uart_tx_ctrl_in   uart_tx_ctrl_in,
    output var uart_tx_pkg::t_uart_tx_ctrl_out  uart_tx_ctrl_out
);
    import uart_tx_pkg::*;

    t_states state;
    t_states next_state;

    // **************************************************
    // State register
    // **************************************************

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // **************************************************
    // Next state
    // **************************************************

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (write_din)
                    next_state = SEND_START;
            end
            SEND_START: begin
                if (uart_tx_ctrl_in.t1)
                    next_state = CLEAR_TIMER;
            end
            // One cycle with te low so the timer restarts from zero
            CLEAR_TIMER: begin
                next_state = SEND_DATA;
            end
            SEND_DATA: begin
                if (uart_tx_ctrl_in.t1)
                    next_state = TEST_EOC;
            end
            TEST_EOC: begin
                if (uart_tx_ctrl_in.eoc_dcount)
                    next_state = SEND_STOP;
                else
                    next_state = SHIFT_COUNT;
            end
            SHIFT_COUNT: begin
                next_state = SEND_DATA;
            end
            SEND_STOP: begin
                if (uart_tx_ctrl_in.t1)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // **************************************************
    // Moore outputs
    // **************************************************

    always_comb begin
        uart_tx_ctrl_out = '0;
        case (state)
            IDLE: begin
                uart_tx_ctrl_out.ena_load   = 1'b1;
                uart_tx_ctrl_out.clr_dcount = 1'b1;
            end
            SEND_START: begin
                uart_tx_ctrl_out.te     = 1'b1;
                uart_tx_ctrl_out.clr_tx = 1'b1;
            end
            SEND_DATA: begin
                uart_tx_ctrl_out.te     = 1'b1;
                uart_tx_ctrl_out.ena_tx = 1'b1;
            end
            SHIFT_COUNT: begin
                uart_tx_ctrl_out.ena_shift  = 1'b1;
                uart_tx_ctrl_out.ena_dcount = 1'b1;
            end
            SEND_STOP: begin
                uart_tx_ctrl_out.te     = 1'b1;
                uart_tx_ctrl_out.set_tx = 1'b1;
            end
            default: uart_tx_ctrl_out = '0;
        endcase
    end

    // Busy flag in the register block relies on this
    a_te_not_idle: assert property (@(posedge clk) disable iff (!resetN)
        uart_tx_ctrl_out.te |-> !uart_tx_ctrl_out.ena_load);

    // tx must hold its level across the gap states
    a_tx_hold_gap: assert property (@(posedge clk) disable iff (!resetN)
        (state inside {CLEAR_TIMER, TEST_EOC, SHIFT_COUNT}) |->
            !(uart_tx_ctrl_out.clr_tx || uart_tx_ctrl_out.ena_tx || uart_tx_ctrl_out.set_tx));

endmodule

// File: uart_tx_datapath.sv
// UART transmit datapath with baud timer, shift register, bit counter and tx flip-flop
`timescale 1ns/1ps

module uart_tx_datapath #(
    parameter int DIV_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                resetN,
    input  logic                                write_din,
    input  logic [7:0]                          data_byte,
    input  logic [DIV_WIDTH-1:0]                divisor,
    input  var uart_tx_pkg::t_uart_tx_ctrl_out  uart_tx_ctrl_out,
    output var uart_tx_pkg::t_uart_tx_ctrl_in   uart_tx_ctrl_in,
    output logic                                tx
);
    import uart_tx_pkg::*;

    logic [DIV_WIDTH-1:0] timer;
    logic                 t1;
    logic [DATA_BITS-1:0] shift_reg;
    logic [2:0]           dcount;

    // **************************************************
    // Bit timer
    // **************************************************

    // Last cycle of a bit period
    assign t1 = uart_tx_ctrl_out.te && (timer == divisor - DIV_WIDTH'(1));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            timer <= '0;
        end else if (!uart_tx_ctrl_out.te || t1) begin
            timer <= '0;
        end else begin
            timer <= timer + DIV_WIDTH'(1);
        end
    end

    // Shift register sending the LSB first
    always_ff @(posedge clk) begin
        if (uart_tx_ctrl_out.ena_load && write_din)
            shift_reg <= data_byte;
        else if (uart_tx_ctrl_out.ena_shift)
            shift_reg <= shift_reg >> 1;
    end

    // Data bit counter
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            dcount <= '0;
        end else if (uart_tx_ctrl_out.clr_dcount) begin
            dcount <= '0;
        end else if (uart_tx_ctrl_out.ena_dcount) begin
            dcount <= dcount + 3'd1;
        end
    end

    always_comb begin
        uart_tx_ctrl_in.t1         = t1;
        uart_tx_ctrl_in.eoc_dcount = (dcount == 3'(DATA_BITS - 1));
    end

    // **************************************************
    // Serial output
    // **************************************************

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            tx <= STOP_BIT;
        end else if (uart_tx_ctrl_out.clr_tx) begin
            tx <= START_BIT;
        end else if (uart_tx_ctrl_out.ena_tx) begin
            tx <= shift_reg[0];
        end else if (uart_tx_ctrl_out.set_tx) begin
            tx <= STOP_BIT;
        end
    end

    // A zero divisor would stretch each bit over the whole timer range
    a_div_nonzero: assert property (@(posedge clk) disable iff (!resetN)
        uart_tx_ctrl_out.te |-> (divisor != '0));

endmodule

// File: uart_axil_regs.sv
// AXI4-Lite register block holding the divisor, data byte and busy status of the UART
`timescale 1ns/1ps

module uart_axil_regs #(
    parameter int DIV_WIDTH   = 16,
    parameter int DEFAULT_DIV = 16
) (
    input  logic                         clk,
    input  logic                         resetN,
    input  var uart_axil_pkg::t_axil_req axil_req,
    output var uart_axil_pkg::t_axil_rsp axil_rsp,
    input  logic                         busy,
    output logic                         write_din,
    output logic [7:0]                   data_byte,
    output logic [DIV_WIDTH-1:0]         divisor
);
    import uart_axil_pkg::*;

    logic                   wr_open;
    logic                   aw_done;
    logic                   w_done;
    logic [AXIL_ADDR_W-1:0] aw_addr_q;
    logic [AXIL_DATA_W-1:0] w_data_q;
    logic [3:0]             w_strb_q;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   awready;
    logic                   wready;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic                   wr_fire;
    logic                   wr_err;
    logic                   data_stall;
    logic [AXIL_ADDR_W-1:0] wr_addr;
    logic [3:0]             wr_strb;
    t_wr_word               wr_word;
    logic [15:0]            div_cur;
    logic [15:0]            div_merge;
    logic [AXIL_DATA_W-1:0] rd_word;
    logic [1:0]             rd_resp;

    // **************************************************
    // Write channel
    // **************************************************

    // Address and data may arrive in either order
    assign wr_addr = aw_done ? aw_addr_q : axil_req.awaddr;
    assign wr_word = w_done ? w_data_q : axil_req.wdata;
    assign wr_strb = w_done ? w_strb_q : axil_req.wstrb;

    // Hold off a data write, or data with no address yet, until the frame ends
    assign data_stall = busy && ((wr_addr == ADDR_DATA) || !(aw_done || axil_req.awvalid));

    assign awready = wr_open && !aw_done && !data_stall;
    assign wready  = wr_open && !w_done && !data_stall;
    assign aw_hs   = axil_req.awvalid && awready;
    assign w_hs    = axil_req.wvalid && wready;
    assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
    assign wr_err  = !((wr_addr == ADDR_DIV) || (wr_addr == ADDR_DATA));

    // Byte lanes 0 and 1 of the divisor follow wstrb
    assign div_cur   = 16'(divisor);
    assign div_merge = {wr_strb[1] ? wr_word.div.divisor[15:8] : div_cur[15:8],
                        wr_strb[0] ? wr_word.div.divisor[7:0]  : div_cur[7:0]};

    always_ff @(posedge clk) begin
        if (aw_hs)
            aw_addr_q <= axil_req.awaddr;
        if (w_hs) begin
            w_data_q <= axil_req.wdata;
            w_strb_q <= axil_req.wstrb;
        end
        if (wr_fire)
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            wr_open   <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            bvalid    <= 1'b0;
            write_din <= 1'b0;
            divisor   <= DIV_WIDTH'(DEFAULT_DIV);
            data_byte <= '0;
        end else begin
            write_din <= 1'b0;
            if (wr_fire) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                wr_open <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_addr == ADDR_DIV)
                    divisor <= DIV_WIDTH'(div_merge);
                // Accepted data write starts the frame
                if ((wr_addr == ADDR_DATA) && wr_strb[0]) begin
                    data_byte <= wr_word.data.data_byte;
                    write_din <= 1'b1;
                end
            end else begin
                if (aw_hs)
                    aw_done <= 1'b1;
                if (w_hs)
                    w_done <= 1'b1;
                if (bvalid) begin
                    if (axil_req.bready)
                        bvalid <= 1'b0;
                end else begin
                    wr_open <= 1'b1;
                end
            end
        end
    end

    // **************************************************
    // Read channel
    // **************************************************

    assign ar_hs = axil_req.arvalid && arready;

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            ADDR_DIV:    rd_word = AXIL_DATA_W'(divisor);
            ADDR_DATA:   rd_word = AXIL_DATA_W'(data_byte);
            ADDR_STATUS: rd_word = AXIL_DATA_W'(busy);
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (ar_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid) begin
            if (axil_req.rready)
                rvalid <= 1'b0;
        end else begin
            arready <= 1'b1;
        end
    end

    always_comb begin
        axil_rsp.awready = awready;
        axil_rsp.wready  = wready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    // A new frame may only start from an idle controller
    a_load_when_idle: assert property (@(posedge clk) disable iff (!resetN)
        write_din |-> !busy);

endmodule

// File: uart_tx_top.sv
// UART transmitter top level joining the AXI4-Lite registers, controller and datapath
`timescale 1ns/1ps

module uart_tx_top #(
    parameter int DIV_WIDTH   = 16,
    parameter int DEFAULT_DIV = 16
) (
    input  logic                         clk,
    input  logic                         resetN,
    input  var uart_axil_pkg::t_axil_req axil_req,
    output var uart_axil_pkg::t_axil_rsp axil_rsp,
    output logic                         tx
);
    import uart_tx_pkg::*;

    t_uart_tx_ctrl_out    ctrl_out;
    t_uart_tx_ctrl_in     ctrl_in;
    logic                 busy;
    logic                 write_din;
    logic [7:0]           data_byte;
    logic [DIV_WIDTH-1:0] divisor;

    // Controller sits in IDLE exactly when it can load
    assign busy = ~ctrl_out.ena_load;

    uart_axil_regs #(
        .DIV_WIDTH   (DIV_WIDTH),
        .DEFAULT_DIV (DEFAULT_DIV)
    ) i_uart_axil_regs (
        .clk       (clk),
        .resetN    (resetN),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .busy      (busy),
        .write_din (write_din),
        .data_byte (data_byte),
        .divisor   (divisor)
    );

    uart_tx_ctrl i_uart_tx_ctrl (
        .clk              (clk),
        .resetN           (resetN),
        .write_din        (write_din),
        .uart_tx_ctrl_in  (ctrl_in),
        .uart_tx_ctrl_out (ctrl_out)
    );

    uart_tx_datapath #(
        .DIV_WIDTH (DIV_WIDTH)
    ) i_uart_tx_datapath (
        .clk              (clk),
        .resetN           (resetN),
        .write_din        (write_din),
        .data_byte        (data_byte),
        .divisor          (divisor),
        .uart_tx_ctrl_out (ctrl_out),
        .uart_tx_ctrl_in  (ctrl_in),
        .tx               (tx)
    );

endmodule

// File: tb_uart_tx.sv
// Self-checking testbench for the UART transmitter with AXI4-Lite driver and frame decoder
`timescale 1ns/1ps

module tb_uart_tx;
    import uart_axil_pkg::*;
    import uart_tx_pkg::*;

    localparam int WAIT_LIMIT   = 2000;
    localparam int POLL_LIMIT   = 500;
    localparam int RESET_DIV    = 16;

    // One decoded or expected serial frame
    typedef struct packed {
        logic       stop;
        logic [7:0] data;
    } t_frame;

    logic      clk = 1'b0;
    logic      resetN;
    t_axil_req axil_req;
    t_axil_rsp axil_rsp;
    logic      tx;

    t_frame exp_q[$];
    t_frame got_q[$];
    int     cur_div;
    int     frames_sent;
    int     frames_seen;
    int     frames_checked;
    int     seed;

    uart_tx_top i_uart_tx_top (
        .clk      (clk),
        .resetN   (resetN),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .tx       (tx)
    );

    always #10 clk = ~clk;

    // **************************************************
    // Checks and reference
    // **************************************************

    task automatic abort_sim();
        $display("Something failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_rsp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_sim();
        end
    endtask

    // Expected frame carries the byte and a high stop bit
    function automatic t_frame frame_expected(input logic [7:0] b);
        t_frame f;
        f.data = b;
        f.stop = 1'b1;
        return f;
    endfunction

    // **************************************************
    // AXI4-Lite driver
    // **************************************************

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input int hold, output logic [1:0] resp);
        int   cnt;
        logic aw_wait;
        logic w_wait;
        logic aw_fire;
        logic w_fire;
        cnt     = 0;
        aw_wait = 1'b1;
        w_wait  = 1'b1;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.bready  <= 1'b0;
        // Ready seen mid-cycle means the transfer happens on the next edge
        while (aw_wait || w_wait) begin
            @(negedge clk);
            aw_fire = aw_wait && axil_rsp.awready;
            w_fire  = w_wait && axil_rsp.wready;
            @(posedge clk);
            if (aw_fire) begin
                axil_req.awvalid <= 1'b0;
                aw_wait = 1'b0;
            end
            if (w_fire) begin
                axil_req.wvalid <= 1'b0;
                w_wait = 1'b0;
            end
            cnt++;
            if ((aw_wait || w_wait) && cnt >= WAIT_LIMIT) begin
                $display("Timeout: write to address %h was never accepted", addr);
                abort_sim();
            end
        end
        cnt = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            cnt++;
            if (cnt >= WAIT_LIMIT) begin
                $display("Timeout: no write response for address %h", addr);
                abort_sim();
            end
            @(negedge clk);
        end
        resp = axil_rsp.bresp;
        // Response must hold while bready stays low
        repeat (hold) begin
            @(negedge clk);
            check_bit("bvalid", axil_rsp.bvalid, 1'b1);
            check_rsp("bresp", axil_rsp.bresp, resp);
            check_bit("awready", axil_rsp.awready, 1'b0);
        end
        @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int   cnt;
        logic ar_wait;
        cnt     = 0;
        ar_wait = 1'b1;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b0;
        while (ar_wait) begin
            @(negedge clk);
            ar_wait = !axil_rsp.arready;
            @(posedge clk);
            if (!ar_wait)
                axil_req.arvalid <= 1'b0;
            cnt++;
            if (ar_wait && cnt >= WAIT_LIMIT) begin
                $display("Timeout: read of address %h was never accepted", addr);
                abort_sim();
            end
        end
        cnt = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            cnt++;
            if (cnt >= WAIT_LIMIT) begin
                $display("Timeout: no read data for address %h", addr);
                abort_sim();
            end
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic set_divisor(input int value);
        logic [1:0] resp;
        axil_write(ADDR_DIV, 32'(value), 0, resp);
        check_rsp("bresp", resp, RESP_OKAY);
        cur_div = value;
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [1:0] resp;
        exp_q.push_back(frame_expected(b));
        frames_sent++;
        axil_write(ADDR_DATA, {24'h0, b}, 0, resp);
        check_rsp("bresp", resp, RESP_OKAY);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        axil_read(ADDR_STATUS, status, resp);
        while (status[0] !== 1'b0) begin
            polls++;
            if (polls >= POLL_LIMIT) begin
                $display("Timeout: transmitter stayed busy");
                abort_sim();
            end
            axil_read(ADDR_STATUS, status, resp);
        end
    endtask

    task automatic wait_all_checked();
        int cnt;
        cnt = 0;
        while (frames_checked != frames_sent) begin
            cnt++;
            if (cnt >= WAIT_LIMIT) begin
                $display("Timeout: not every sent frame was decoded");
                abort_sim();
            end
            @(negedge clk);
        end
    endtask

    // Frame position counted in cycles from the falling start edge
    task automatic advance_to(inout int pos, input int target);
        repeat (target - pos) @(negedge clk);
        pos = target;
    endtask

    // **************************************************
    // Serial frame decoder
    // **************************************************

    initial begin : decode_frames
        t_frame f;
        int     d;
        int     pos;
        int     idle_cnt;
        int     bit_start;
        idle_cnt = 0;
        @(negedge clk);
        while (resetN !== 1'b1) begin
            idle_cnt++;
            if (idle_cnt >= WAIT_LIMIT) begin
                $display("Timeout: reset was never released");
                abort_sim();
            end
            @(negedge clk);
        end
        forever begin
            idle_cnt = 0;
            @(negedge clk);
            while (tx !== 1'b0) begin
                if (frames_sent > frames_seen)
                    idle_cnt++;
                else
                    idle_cnt = 0;
                if (idle_cnt >= WAIT_LIMIT) begin
                    $display("Timeout: tx never started an expected frame");
                    abort_sim();
                end
                @(negedge clk);
            end
            d   = cur_div;
            pos = 0;
            f   = '0;
            advance_to(pos, (d + 1) / 2);
            check_bit("tx start bit", tx, 1'b0);
            // Bits 0 to 6 last D+2 cycles and bit 7 only D+1
            for (int k = 0; k < DATA_BITS; k++) begin
                bit_start = (d + 1) + k * (d + 2);
                if (k == DATA_BITS - 1)
                    advance_to(pos, bit_start + (d + 1) / 2);
                else
                    advance_to(pos, bit_start + (d + 2) / 2);
                f.data = {tx, f.data[7:1]};
            end
            advance_to(pos, (d + 1) + (DATA_BITS - 1) * (d + 2) + (d + 1) + d / 2);
            f.stop = tx;
            got_q.push_back(f);
            frames_seen++;
        end
    end

    // Compare each decoded frame with the oldest expected one
    initial begin : compare_frames
        t_frame got;
        t_frame exp;
        forever begin
            @(negedge clk);
            if (got_q.size() > 0) begin
                got = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("A frame appeared on tx although none was sent");
                    abort_sim();
                end
                exp = exp_q.pop_front();
                check_byte("frame data", got.data, exp.data);
                check_bit("frame stop bit", got.stop, exp.stop);
                frames_checked++;
            end
        end
    end

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin : run_tests
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [31:0] rnd;
        int          base;
        int          div_val;
        seed           = 50;
        cur_div        = RESET_DIV;
        frames_sent    = 0;
        frames_seen    = 0;
        frames_checked = 0;
        resetN   <= 1'b0;
        axil_req <= '0;
        repeat (2) @(posedge clk);
        resetN <= 1'b1;

        // Reset state
        @(negedge clk);
        check_bit("tx", tx, 1'b1);
        check_bit("bvalid", axil_rsp.bvalid, 1'b0);
        check_bit("rvalid", axil_rsp.rvalid, 1'b0);
        axil_read(ADDR_STATUS, rdata, resp);
        check_rsp("rresp", resp, RESP_OKAY);
        check_word("status", rdata, 32'h0);
        axil_read(ADDR_DIV, rdata, resp);
        check_word("divisor", rdata, 32'(RESET_DIV));

        // Register map and error responses
        set_divisor(12);
        axil_read(ADDR_DIV, rdata, resp);
        check_rsp("rresp", resp, RESP_OKAY);
        check_word("divisor", rdata, 32'd12);
        axil_write(ADDR_STATUS, 32'h1, 0, resp);
        check_rsp("bresp", resp, RESP_SLVERR);
        axil_write(4'hc, 32'h5a, 0, resp);
        check_rsp("bresp", resp, RESP_SLVERR);
        axil_read(4'hc, rdata, resp);
        check_rsp("rresp", resp, RESP_SLVERR);
        check_word("unmapped rdata", rdata, 32'h0);

        // Write response held while bready is low
        axil_write(ADDR_DIV, 32'd10, 5, resp);
        check_rsp("bresp", resp, RESP_OKAY);
        cur_div = 10;

        // Single frame with busy seen during it
        send_byte(8'ha5);
        axil_read(ADDR_STATUS, rdata, resp);
        check_word("status", rdata, 32'h1);
        wait_idle();
        axil_read(ADDR_DATA, rdata, resp);
        check_word("data", rdata, 32'ha5);

        // Second write stalls until the first frame is over
        base = frames_seen;
        send_byte(8'h3c);
        send_byte(8'hc3);
        if (frames_seen != base + 1) begin
            $display("Second data write was accepted before the first frame ended");
            abort_sim();
        end
        wait_idle();

        // Random bytes at random divisors
        repeat (20) begin
            rnd     = $random(seed);
            div_val = 8 + int'(rnd[15:8]) % 33;
            set_divisor(div_val);
            rnd = $random(seed);
            send_byte(rnd[7:0]);
            wait_idle();
        end

        wait_all_checked();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: uart_tx_top.f
uart_tx_pkg.sv
uart_axil_pkg.sv
uart_tx_ctrl.sv
uart_tx_datapath.sv
uart_axil_regs.sv
uart_tx_top.sv
tb_uart_tx.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the UART transmitter testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_uart_tx -f uart_tx_top.f -o sim_uart_tx
sim_status=0
./obj_dir/sim_uart_tx > sim.log 2>&1 || sim_status=$?
cat sim.log
if grep -q "Everything OK" sim.log; then
    exit 0
fi
echo "Simulation did not pass, exit status $sim_status"
exit 1
